/* decode_stage.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module decode_stage (
    input  logic                 clk_wfi,
    input  logic                 rstn_sync,
    input  logic                 if2id_valid_i,
    input  rv_pipe_pkg::if2id_t  if2id_i,
    rv_wb_if.sink                wb,
    output logic                 redirect_o,
    output logic [`XLEN-1:0]     redirect_pc_o,
    output logic                 id2exe_valid_o,
    output rv_pipe_pkg::id2exe_t id2exe_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_j;
    logic [`XLEN-1:0]       imm;
    rv_isa_pkg::alu_op_e    alu_op;
    logic                   supported;
    logic                   is_jal;
    logic                   rs1_zero_sel;
    logic                   rs2_imm_sel;
    logic                   dec_valid;
    logic                   rd_wr;

    function automatic rv_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        rv_isa_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::F3_ADD:  op = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   op = rv_isa_pkg::ALU_OR;
            default:             op = rv_isa_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = if2id_i.inst[6:0];
    assign rd     = if2id_i.inst[11:7];
    assign funct3 = if2id_i.inst[14:12];
    assign rs1    = if2id_i.inst[19:15];
    assign rs2    = if2id_i.inst[24:20];
    assign funct7 = if2id_i.inst[31:25];

    assign imm_i = {{(`XLEN-12){if2id_i.inst[31]}}, if2id_i.inst[31:20]};
    assign imm_u = {if2id_i.inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){if2id_i.inst[31]}}, if2id_i.inst[19:12], if2id_i.inst[20],
                    if2id_i.inst[30:21], 1'b0};

    always_comb begin
        supported    = 1'b0;
        is_jal       = 1'b0;
        rs1_zero_sel = 1'b0;
        rs2_imm_sel  = 1'b0;
        imm          = '0;
        alu_op       = rv_isa_pkg::ALU_ADD;
        case (opcode)
            rv_isa_pkg::OP: begin
                // SUB and SRA are the only funct7 variants
                supported = (funct7 == 7'b0000000) ||
                            (funct7 == 7'b0100000 &&
                             (funct3 == rv_isa_pkg::F3_ADD || funct3 == rv_isa_pkg::F3_SR));
                alu_op    = alu_sel(funct3, funct7[5]);
            end
            rv_isa_pkg::OP_IMM: begin
                if (funct3 == rv_isa_pkg::F3_SLL) begin
                    supported = (funct7 == 7'b0000000);
                end else if (funct3 == rv_isa_pkg::F3_SR) begin
                    supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    supported = 1'b1;
                end
                alu_op      = alu_sel(funct3, funct3 == rv_isa_pkg::F3_SR && funct7[5]);
                rs2_imm_sel = 1'b1;
                imm         = imm_i;
            end
            rv_isa_pkg::LUI: begin
                supported    = 1'b1;
                rs1_zero_sel = 1'b1;
                rs2_imm_sel  = 1'b1;
                imm          = imm_u;
            end
            rv_isa_pkg::JAL: begin
                supported = 1'b1;
                is_jal    = 1'b1;
                imm       = imm_j;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // Unsupported encodings leave as bubbles
    assign dec_valid = if2id_valid_i & supported;
    assign rd_wr     = dec_valid & (rd != '0);

    assign redirect_o    = if2id_valid_i & is_jal;
    assign redirect_pc_o = if2id_i.pc + imm_j;

    regfile u_regfile (
        .clk_wfi    (clk_wfi),
        .rstn_sync  (rstn_sync),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb         (wb)
    );

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            id2exe_valid_o <= 1'b0;
            id2exe_o       <= '0;
        end else begin
            id2exe_valid_o        <= dec_valid;
            id2exe_o.pc           <= if2id_i.pc;
            id2exe_o.rs1          <= rs1;
            id2exe_o.rs2          <= rs2;
            id2exe_o.rs1_data     <= rs1_data;
            id2exe_o.rs2_data     <= rs2_data;
            id2exe_o.imm          <= imm;
            id2exe_o.alu_op       <= alu_op;
            id2exe_o.rs1_zero_sel <= rs1_zero_sel;
            id2exe_o.rs2_imm_sel  <= rs2_imm_sel;
            id2exe_o.link_sel     <= is_jal;
            id2exe_o.rd           <= rd;
            id2exe_o.rd_wr        <= rd_wr;
        end
    end

endmodule

/* exe_stage.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module exe_stage (
    input  logic                 clk_wfi,
    input  logic                 rstn_sync,
    input  logic                 id2exe_valid_i,
    input  rv_pipe_pkg::id2exe_t id2exe_i,
    rv_wb_if.source              wb
);

    localparam int SHAMT_W = $clog2(`XLEN);

    rv_pipe_pkg::exe2wb_t exe2wb_q;
    logic                 exe2wb_valid_q;
    logic                 fwd_rs1;
    logic                 fwd_rs2;
    logic [`XLEN-1:0]     rs1_val;
    logic [`XLEN-1:0]     rs2_val;
    logic [`XLEN-1:0]     src1;
    logic [`XLEN-1:0]     src2;
    logic [`XLEN-1:0]     alu_out;
    logic [`XLEN-1:0]     result;
    logic [SHAMT_W-1:0]   shamt;

    // Writeback result forwarded into execute
    assign fwd_rs1 = exe2wb_q.rd_wr & (exe2wb_q.rd == id2exe_i.rs1);
    assign fwd_rs2 = exe2wb_q.rd_wr & (exe2wb_q.rd == id2exe_i.rs2);
    assign rs1_val = fwd_rs1 ? exe2wb_q.result : id2exe_i.rs1_data;
    assign rs2_val = fwd_rs2 ? exe2wb_q.result : id2exe_i.rs2_data;

    assign src1  = id2exe_i.rs1_zero_sel ? '0 : rs1_val;
    assign src2  = id2exe_i.rs2_imm_sel ? id2exe_i.imm : rs2_val;
    assign shamt = src2[SHAMT_W-1:0];

    always_comb begin
        case (id2exe_i.alu_op)
            rv_isa_pkg::ALU_ADD:  alu_out = src1 + src2;
            rv_isa_pkg::ALU_SUB:  alu_out = src1 - src2;
            rv_isa_pkg::ALU_SLL:  alu_out = src1 << shamt;
            rv_isa_pkg::ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            rv_isa_pkg::ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, src1 < src2};
            rv_isa_pkg::ALU_XOR:  alu_out = src1 ^ src2;
            rv_isa_pkg::ALU_SRL:  alu_out = src1 >> shamt;
            rv_isa_pkg::ALU_SRA:  alu_out = $unsigned($signed(src1) >>> shamt);
            rv_isa_pkg::ALU_OR:   alu_out = src1 | src2;
            default:              alu_out = src1 & src2;
        endcase
    end

    // JAL links the return address
    assign result = id2exe_i.link_sel ? id2exe_i.pc + `XLEN'(4) : alu_out;

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            exe2wb_valid_q <= 1'b0;
            exe2wb_q       <= '0;
        end else begin
            exe2wb_valid_q  <= id2exe_valid_i;
            exe2wb_q.pc     <= id2exe_i.pc;
            exe2wb_q.rd     <= id2exe_i.rd;
            exe2wb_q.rd_wr  <= id2exe_i.rd_wr;
            exe2wb_q.result <= result;
        end
    end

    assign wb.valid = exe2wb_valid_q;
    assign wb.wr    = exe2wb_q.rd_wr;
    assign wb.rd    = exe2wb_q.rd;
    assign wb.data  = exe2wb_q.result;
    assign wb.pc    = exe2wb_q.pc;

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module fetch_unit (
    input  logic                clk_wfi,
    input  logic                rstn_sync,
    input  logic                redirect_i,
    input  logic [`XLEN-1:0]    redirect_pc_i,
    input  logic                imem_busy_i,
    input  logic [31:0]         imem_rdata_i,
    output logic                imem_en_o,
    output logic [`XLEN-1:0]    imem_addr_o,
    output logic                if2id_valid_o,
    output rv_pipe_pkg::if2id_t if2id_o
);

    logic [`XLEN-1:0] pc_q;
    logic             accept;

    // Word at pc_q is taken only when memory answers and no jump kills it
    assign accept      = imem_en_o & ~imem_busy_i & ~redirect_i;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            pc_q          <= `RESET_PC;
            imem_en_o     <= 1'b0;
            if2id_valid_o <= 1'b0;
            if2id_o.pc    <= `RESET_PC;
            if2id_o.inst  <= `INST_NOP;
        end else begin
            imem_en_o <= 1'b1;
            // Redirect wins over busy
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (accept) begin
                pc_q <= pc_q + `XLEN'(4);
            end
            if2id_valid_o <= accept;
            if2id_o.pc    <= pc_q;
            if2id_o.inst  <= accept ? imem_rdata_i : `INST_NOP;
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module regfile (
    input  logic                   clk_wfi,
    input  logic                   rstn_sync,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    rv_wb_if.sink                  wb
);

    logic [`XLEN-1:0] regs [31:1];

    // x0 reads zero, a same-cycle write is passed straight through
    function automatic logic [`XLEN-1:0] read_port(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic                   wr,
        input logic [`REG_ADDR_W-1:0] wr_addr,
        input logic [`XLEN-1:0]       wr_data
    );
        logic [`XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wr && wr_addr == addr) begin
            val = wr_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i, wb.wr, wb.rd, wb.data);
        rs2_data_o = read_port(rs2_addr_i, wb.wr, wb.rd, wb.data);
    end

    always_ff @(posedge clk_wfi or negedge rstn_sync) begin
        if (!rstn_sync) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

/* rv_core_assert.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_core_assert (
    input logic               clk_wfi,
    input logic               rstn_sync,
    input logic               imem_en_i,
    input logic [`XLEN-1:0]   imem_addr_i,
    input logic               retire_valid_i,
    input logic [`XLEN-1:0]   retire_pc_i
);

    // Fetch enable is registered, so it is seen low one edge into reset
    en_low_in_reset: assert property (@(posedge clk_wfi) !rstn_sync |=> !imem_en_i)
        else $error("imem_en_o high while reset was asserted");

    addr_aligned: assert property (
        @(posedge clk_wfi) disable iff (!rstn_sync) imem_addr_i[1:0] == 2'b00)
        else $error("imem_addr_o not word aligned");

    retire_pc_aligned: assert property (
        @(posedge clk_wfi) disable iff (!rstn_sync)
        retire_valid_i |-> retire_pc_i[1:0] == 2'b00)
        else $error("retire_pc_o not word aligned");

endmodule

/* rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Datapath width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define INST_NOP 32'h0000_0013

`endif

/* rv_core_top.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_wb_if.sv
regfile.sv
fetch_unit.sv
decode_stage.sv
exe_stage.sv
rv_core_top.sv
rv_core_assert.sv
tb_rv_core.sv

/* rv_core_top.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                   clk_wfi,
    input  logic                   rstn_sync,
    output logic                   imem_en_o,
    output logic [`XLEN-1:0]       imem_addr_o,
    input  logic [31:0]            imem_rdata_i,
    input  logic                   imem_busy_i,
    output logic                   retire_valid_o,
    output logic [`XLEN-1:0]       retire_pc_o,
    output logic [`REG_ADDR_W-1:0] retire_rd_o,
    output logic [`XLEN-1:0]       retire_data_o
);

    logic                 redirect;
    logic [`XLEN-1:0]     redirect_pc;
    logic                 if2id_valid;
    rv_pipe_pkg::if2id_t  if2id;
    logic                 id2exe_valid;
    rv_pipe_pkg::id2exe_t id2exe;

    rv_wb_if wb_bus ();

    fetch_unit u_fetch (
        .clk_wfi       (clk_wfi),
        .rstn_sync     (rstn_sync),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_busy_i   (imem_busy_i),
        .imem_rdata_i  (imem_rdata_i),
        .imem_en_o     (imem_en_o),
        .imem_addr_o   (imem_addr_o),
        .if2id_valid_o (if2id_valid),
        .if2id_o       (if2id)
    );

    decode_stage u_decode (
        .clk_wfi        (clk_wfi),
        .rstn_sync      (rstn_sync),
        .if2id_valid_i  (if2id_valid),
        .if2id_i        (if2id),
        .wb             (wb_bus),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .id2exe_valid_o (id2exe_valid),
        .id2exe_o       (id2exe)
    );

    exe_stage u_exe (
        .clk_wfi        (clk_wfi),
        .rstn_sync      (rstn_sync),
        .id2exe_valid_i (id2exe_valid),
        .id2exe_i       (id2exe),
        .wb             (wb_bus)
    );

    // Retire port mirrors the writeback bus
    assign retire_valid_o = wb_bus.valid;
    assign retire_pc_o    = wb_bus.pc;
    assign retire_rd_o    = wb_bus.rd;
    assign retire_data_o  = wb_bus.data;

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // SRL and SRA, told apart by funct7
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* rv_pipe_pkg.sv */
`include "rv_core_macros.svh"

package rv_pipe_pkg;

    // IF/ID payload
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } if2id_t;

    // ID/EXE payload
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        rv_isa_pkg::alu_op_e    alu_op;
        logic                   rs1_zero_sel;
        logic                   rs2_imm_sel;
        logic                   link_sel;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_wr;
    } id2exe_t;

    // EXE/WB payload
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_wr;
        logic [`XLEN-1:0]       result;
    } exe2wb_t;

endpackage

/* rv_wb_if.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

interface rv_wb_if;

    logic                   valid;
    logic                   wr;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
    logic [`XLEN-1:0]       pc;

    // Driven by execute
    modport source (output valid, wr, rd, data, pc);

    // Register file and retire port
    modport sink (input valid, wr, rd, data, pc);

endinterface

/* tb_rv_core.sv */
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module tb_rv_core;

    localparam int RUN_CYCLES = 250;
    localparam int NUM_RUNS   = 8;
    localparam int WAIT_LIMIT = 200;
    localparam int MEM_WORDS  = 1024;

    logic                   clk_wfi = 1'b0;
    logic                   rstn_sync;
    logic                   imem_en;
    logic [`XLEN-1:0]       imem_addr;
    logic [31:0]            imem_rdata;
    logic                   imem_busy;
    logic                   retire_valid;
    logic [`XLEN-1:0]       retire_pc;
    logic [`REG_ADDR_W-1:0] retire_rd;
    logic [`XLEN-1:0]       retire_data;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog_q [$];
    // Retire entries packed as {pc, rd, data}
    logic [68:0] exp_q [$];
    logic [68:0] got_q [$];
    logic [68:0] base_q [$];
    logic [31:0] lfsr = 32'hd391_1b7d;
    logic        busy_mode = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    always #20 clk_wfi = ~clk_wfi;

    rv_core_top u_dut (
        .clk_wfi        (clk_wfi),
        .rstn_sync      (rstn_sync),
        .imem_en_o      (imem_en),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .imem_busy_i    (imem_busy),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    bind rv_core_top rv_core_assert u_assert (
        .clk_wfi        (clk_wfi),
        .rstn_sync      (rstn_sync),
        .imem_en_i      (imem_en_o),
        .imem_addr_i    (imem_addr_o),
        .retire_valid_i (retire_valid_o),
        .retire_pc_i    (retire_pc_o)
    );

    // Combinational instruction memory
    assign imem_rdata = mem[imem_addr[11:2]];

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always @(negedge clk_wfi) begin
        if (busy_mode) begin
            lfsr = lfsr_step(lfsr);
            imem_busy <= lfsr[0];
        end else begin
            imem_busy <= 1'b0;
        end
    end

    always @(negedge clk_wfi) begin
        if (retire_valid === 1'b1) begin
            got_q.push_back({retire_pc, retire_rd, retire_data});
        end
    end

    function automatic logic [31:0] op_r(input logic [2:0] f3, input logic [6:0] f7,
                                         input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rv_isa_pkg::OP};
    endfunction

    function automatic logic [31:0] op_i(input logic [2:0] f3, input int rd,
                                         input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], rv_isa_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] op_lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], rv_isa_pkg::LUI};
    endfunction

    function automatic logic [31:0] op_jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_isa_pkg::JAL};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic [31:0]        r;
        sa = a;
        case (f3)
            rv_isa_pkg::F3_ADD:  r = alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:  r = a << b[4:0];
            rv_isa_pkg::F3_SLT:  r = {31'b0, sa < $signed(b)};
            rv_isa_pkg::F3_SLTU: r = {31'b0, a < b};
            rv_isa_pkg::F3_XOR:  r = a ^ b;
            rv_isa_pkg::F3_SR: begin
                if (alt) begin
                    r = sa >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            rv_isa_pkg::F3_OR:   r = a | b;
            default:             r = a & b;
        endcase
        return r;
    endfunction

    // Unused words carry opcode 0, which never retires
    task automatic load_prog();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[24:0], 7'b0000000};
        end
        foreach (prog_q[i]) begin
            mem[i] = prog_q[i];
        end
    endtask

    // ISA-level model of the subset, fills exp_q
    task automatic model_run();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic        ok;
        int          steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        exp_q.delete();
        pc = `RESET_PC;
        steps = 0;
        while ((pc >> 2) < prog_q.size() && steps < 100) begin
            inst = mem[pc[11:2]];
            f3 = inst[14:12];
            f7 = inst[31:25];
            rd = inst[11:7];
            a = regs[inst[19:15]];
            b = regs[inst[24:20]];
            next_pc = pc + 32'd4;
            ok = 1'b0;
            res = '0;
            case (inst[6:0])
                rv_isa_pkg::OP: begin
                    ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                    res = alu_model(f3, f7[5], a, b);
                end
                rv_isa_pkg::OP_IMM: begin
                    b = {{20{inst[31]}}, inst[31:20]};
                    if (f3 == 3'd1) begin
                        ok = (f7 == 7'h00);
                    end else if (f3 == 3'd5) begin
                        ok = (f7 == 7'h00) || (f7 == 7'h20);
                    end else begin
                        ok = 1'b1;
                    end
                    res = alu_model(f3, f3 == 3'd5 && f7[5], a, b);
                end
                rv_isa_pkg::LUI: begin
                    ok = 1'b1;
                    res = {inst[31:12], 12'b0};
                end
                rv_isa_pkg::JAL: begin
                    ok = 1'b1;
                    res = pc + 32'd4;
                    next_pc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: ok = 1'b0;
            endcase
            if (ok) begin
                exp_q.push_back({pc, rd, res});
                if (rd != 5'd0) begin
                    regs[rd] = res;
                end
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic hold_reset(input bit check);
        repeat (10) begin
            @(negedge clk_wfi);
            if (check) begin
                checks++;
                assert (imem_en === 1'b0 && retire_valid === 1'b0) else begin
                    $display("ERROR imem_en_o %h retire_valid_o %h during reset",
                             imem_en, retire_valid);
                    errors++;
                end
            end
        end
        rstn_sync = 1'b1;
    endtask

    task automatic compare_retire(input int idx, input logic [68:0] got,
                                  input logic [68:0] exp);
        checks += 3;
        assert (got[68:37] === exp[68:37]) else begin
            $display("ERROR retire_pc_o #%0d: got %h expected %h", idx, got[68:37], exp[68:37]);
            errors++;
        end
        assert (got[36:32] === exp[36:32]) else begin
            $display("ERROR retire_rd_o #%0d: got %h expected %h", idx, got[36:32], exp[36:32]);
            errors++;
        end
        assert (got[31:0] === exp[31:0]) else begin
            $display("ERROR retire_data_o #%0d: got %h expected %h", idx, got[31:0], exp[31:0]);
            errors++;
        end
    endtask

    // Loads prog_q, runs it from reset and checks the retires against the model
    task automatic run_prog(input string name, input bit busy_on);
        int cycles;
        busy_mode = busy_on;
        got_q.delete();
        @(negedge clk_wfi);
        rstn_sync = 1'b0;
        load_prog();
        model_run();
        hold_reset(1'b0);
        cycles = 0;
        while (got_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(posedge clk_wfi);
            cycles++;
        end
        // Catch retires beyond the expected list
        repeat (10) @(posedge clk_wfi);
        busy_mode = 1'b0;
        checks++;
        assert (got_q.size() == exp_q.size()) else begin
            $display("%s retired %0d instructions where %0d were expected",
                     name, got_q.size(), exp_q.size());
            errors++;
        end
        foreach (exp_q[i]) begin
            if (i < got_q.size()) begin
                compare_retire(i, got_q[i], exp_q[i]);
            end
        end
    endtask

    task automatic check_skipped(input logic [31:0] pc);
        foreach (got_q[i]) begin
            checks++;
            assert (got_q[i][68:37] !== pc) else begin
                $display("instruction at %h retired although it should not", pc);
                errors++;
            end
        end
    endtask

    task automatic check_follows(input logic [31:0] jal_pc, input logic [31:0] target);
        foreach (got_q[i]) begin
            if (got_q[i][68:37] === jal_pc && i + 1 < got_q.size()) begin
                checks++;
                assert (got_q[i+1][68:37] === target) else begin
                    $display("ERROR retire_pc_o after JAL at %h: got %h expected %h",
                             jal_pc, got_q[i+1][68:37], target);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %-12s %s, %0d errors", name, (errors == err0) ? "passed" : "failed",
                 errors - err0);
    endtask

    task automatic add_chain();
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 1, 0, -3));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 2, 1, 100));
        prog_q.push_back(op_i(rv_isa_pkg::F3_SLL, 3, 2, 4));
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h20, 4, 1, 3));
        prog_q.push_back(op_i(rv_isa_pkg::F3_SR, 5, 4, 12'h402));
        prog_q.push_back(op_i(rv_isa_pkg::F3_SR, 6, 5, 28));
        prog_q.push_back(op_i(rv_isa_pkg::F3_XOR, 7, 6, -1));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SLT, 7'h00, 8, 7, 6));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SLTU, 7'h00, 9, 8, 7));
        prog_q.push_back(op_r(rv_isa_pkg::F3_OR, 7'h00, 10, 9, 7));
        prog_q.push_back(op_r(rv_isa_pkg::F3_AND, 7'h00, 11, 10, 5));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SLL, 7'h00, 12, 11, 9));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SR, 7'h20, 13, 12, 2));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SR, 7'h00, 14, 13, 2));
        prog_q.push_back(op_i(rv_isa_pkg::F3_SLT, 15, 14, -5));
        prog_q.push_back(op_i(rv_isa_pkg::F3_SLTU, 16, 15, 1));
        prog_q.push_back(op_i(rv_isa_pkg::F3_OR, 17, 16, 12'h7f0));
        prog_q.push_back(op_i(rv_isa_pkg::F3_AND, 18, 17, 12'h0f5));
    endtask

    // JAL at 8 lands on 20, JAL at 24 lands on 32
    task automatic add_jumps();
        prog_q.push_back(op_lui(1, 20'h12345));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 1, 1, 12'h678));
        prog_q.push_back(op_jal(2, 12));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 3, 0, 1));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 4, 0, 2));
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h00, 5, 2, 1));
        prog_q.push_back(op_jal(0, 8));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 6, 0, 3));
        prog_q.push_back(op_lui(7, 20'hfffff));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 8, 7, -1));
    endtask

    task automatic test_reset();
        int err0;
        int cycles;
        err0 = errors;
        prog_q.delete();
        @(negedge clk_wfi);
        rstn_sync = 1'b0;
        load_prog();
        hold_reset(1'b1);
        cycles = 0;
        while (imem_en !== 1'b1 && cycles < 20) begin
            @(negedge clk_wfi);
            cycles++;
        end
        checks += 2;
        assert (imem_en === 1'b1) else begin
            $display("imem_en_o never rose after reset");
            errors++;
        end
        assert (imem_addr === `RESET_PC) else begin
            $display("ERROR imem_addr_o: got %h expected %h", imem_addr, `RESET_PC);
            errors++;
        end
        report_test("reset", err0);
    endtask

    task automatic test_forwarding();
        int err0;
        err0 = errors;
        prog_q.delete();
        add_chain();
        run_prog("forwarding", 1'b0);
        report_test("forwarding", err0);
    endtask

    task automatic test_bypass_x0();
        int err0;
        err0 = errors;
        prog_q.delete();
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 1, 0, 9));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 2, 0, 4));
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h00, 3, 1, 2));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 0, 1, 77));
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h00, 4, 0, 3));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 5, 0, 1));
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h20, 6, 0, 4));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SR, 7'h20, 7, 6, 2));
        prog_q.push_back(op_r(rv_isa_pkg::F3_SLL, 7'h00, 8, 3, 5));
        prog_q.push_back(op_r(rv_isa_pkg::F3_OR, 7'h00, 0, 3, 3));
        prog_q.push_back(op_r(rv_isa_pkg::F3_OR, 7'h00, 10, 0, 0));
        prog_q.push_back(op_r(rv_isa_pkg::F3_XOR, 7'h00, 11, 8, 0));
        run_prog("bypass_x0", 1'b0);
        report_test("bypass_x0", err0);
    endtask

    task automatic test_lui_jal();
        int err0;
        err0 = errors;
        prog_q.delete();
        add_jumps();
        run_prog("lui_jal", 1'b0);
        check_skipped(32'd12);
        check_skipped(32'd16);
        check_skipped(32'd28);
        check_follows(32'd8, 32'd20);
        check_follows(32'd24, 32'd32);
        report_test("lui_jal", err0);
    endtask

    task automatic test_busy();
        int err0;
        err0 = errors;
        prog_q.delete();
        add_jumps();
        add_chain();
        run_prog("no_busy", 1'b0);
        base_q = got_q;
        run_prog("busy", 1'b1);
        checks++;
        assert (got_q.size() == base_q.size()) else begin
            $display("busy run retired %0d instructions, run without busy %0d",
                     got_q.size(), base_q.size());
            errors++;
        end
        foreach (base_q[i]) begin
            if (i < got_q.size()) begin
                compare_retire(i, got_q[i], base_q[i]);
            end
        end
        report_test("busy", err0);
    endtask

    task automatic test_unsupported();
        int err0;
        err0 = errors;
        prog_q.delete();
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 1, 0, 3));
        // ECALL
        prog_q.push_back(32'h0000_0073);
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 2, 1, 4));
        // LW x3, 0(x1)
        prog_q.push_back({12'd0, 5'd1, 3'b010, 5'd3, 7'b0000011});
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h00, 4, 2, 3));
        // MUL encoding
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h01, 5, 4, 4));
        prog_q.push_back(op_i(rv_isa_pkg::F3_ADD, 5, 4, 1));
        // SLLI with a bad funct7
        prog_q.push_back(op_i(rv_isa_pkg::F3_SLL, 6, 5, 12'h405));
        prog_q.push_back(op_r(rv_isa_pkg::F3_ADD, 7'h00, 7, 6, 5));
        run_prog("unsupported", 1'b0);
        check_skipped(32'd4);
        check_skipped(32'd12);
        check_skipped(32'd20);
        check_skipped(32'd28);
        report_test("unsupported", err0);
    endtask

    initial begin
        rstn_sync = 1'b0;
        imem_busy = 1'b0;
        prog_q.delete();
        load_prog();
        test_reset();
        test_forwarding();
        test_bypass_x0();
        test_lui_jal();
        test_busy();
        test_unsupported();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized for every run at its longest
    initial begin
        repeat (RUN_CYCLES * NUM_RUNS) @(posedge clk_wfi);
        $display("watchdog expired after %0d cycles", RUN_CYCLES * NUM_RUNS);
        $display("Something failed");
        $finish;
    end

endmodule
